// File: csa_stream_top.f
+incdir+include
src/csa_pkg.sv
src/fifo_rd_if.sv
src/stream_fifo.sv
src/pack_32_to_40.sv
src/csa_tree.sv
src/unpack_48_to_32.sv
src/csa_stream_top.sv
tb/csa_stream_props.sv
tb/tb_csa_stream_top.sv

// File: include/csa_defines.svh
`ifndef CSA_DEFINES_SVH
`define CSA_DEFINES_SVH

// Stream word width on both AXI-stream sides
`define CSA_WORD_W 32

// One operand of the carry-save tree
`define CSA_OP_W 40

// Tree result, wide enough for four operands without overflow
`define CSA_SUM_W 48

// Entries per FIFO
`define CSA_FIFO_DEPTH 16

// Output FIFO entries that must be free before a group is started
`define CSA_OUT_HEADROOM 6

`endif

// File: run_sim.sh
#!/bin/sh
# Build and run the testbench with Verilator, pass only if the log holds the pass line
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tb_csa_stream_top \
	-f csa_stream_top.f -o sim_tb

./obj_dir/sim_tb > sim.log 2>&1 || true
cat sim.log

grep -qx "PASS: all tests" sim.log

// File: src/csa_pkg.sv
`default_nettype none

`include "csa_defines.svh"

package csa_pkg;

	typedef logic [`CSA_WORD_W - 1 : 0] word_t;

	typedef logic [`CSA_OP_W - 1 : 0] operand_t;

	typedef logic [`CSA_SUM_W - 1 : 0] sum_t;

	// Five stream words, seen by the tree as four operands
	// Word i sits at bit 32*i, operand k at bit 40*k
	typedef union packed {
		word_t [4 : 0] words;
		operand_t [3 : 0] ops;
	} op_group_u;

	// Two sums, sent out as three beats
	// First sum in the low half, beat j at bit 32*j
	typedef union packed {
		sum_t [1 : 0] sums;
		word_t [2 : 0] beats;
	} sum_pair_u;

endpackage

`default_nettype wire

// File: src/csa_stream_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "csa_defines.svh"

module csa_stream_top (
	input logic axis_s_rclk,
	input logic rst_n,
	input logic s_tvalid,
	output logic s_tready,
	input logic [`CSA_WORD_W - 1 : 0] s_tdata,
	output logic m_tvalid,
	input logic m_tready,
	output logic [`CSA_WORD_W - 1 : 0] m_tdata,
	output logic m_tlast,
	output logic err_full,
	output logic err_empty
);

	import csa_pkg::*;

	localparam int LVL_W = $clog2(`CSA_FIFO_DEPTH + 1);

	fifo_rd_if #(.DATA_W(`CSA_WORD_W)) in_rd ();
	fifo_rd_if #(.DATA_W(`CSA_WORD_W + 1)) out_rd ();

	logic in_full;
	logic in_err_full;
	logic in_err_empty;
	logic [LVL_W - 1 : 0] out_free;
	logic out_err_full;
	logic out_err_empty;
	logic op_valid;
	op_group_u ops;
	logic sum_valid;
	sum_t sum;
	logic unp_wen;
	word_t unp_wdata;
	logic unp_last;

	assign s_tready = ~in_full;

	stream_fifo #(.DATA_W(`CSA_WORD_W)) in_fifo (
		.clk(axis_s_rclk),
		.rst_n(rst_n),
		.wen(s_tvalid && s_tready),
		.wdata(s_tdata),
		.full(in_full),
		.free(),
		.rd(in_rd),
		.error_full(in_err_full),
		.error_empty(in_err_empty)
	);

	pack_32_to_40 pack_inst (
		.axis_s_rclk(axis_s_rclk),
		.rst_n(rst_n),
		.rd(in_rd),
		.out_free(out_free),
		.op_valid(op_valid),
		.ops(ops)
	);

	csa_tree tree_inst (
		.axis_s_rclk(axis_s_rclk),
		.rst_n(rst_n),
		.op_valid(op_valid),
		.ops(ops),
		.sum_valid(sum_valid),
		.sum(sum)
	);

	unpack_48_to_32 unpack_inst (
		.axis_s_rclk(axis_s_rclk),
		.rst_n(rst_n),
		.sum_valid(sum_valid),
		.sum(sum),
		.wen(unp_wen),
		.wdata(unp_wdata),
		.last(unp_last)
	);

	// tlast travels as the top bit of each entry
	stream_fifo #(.DATA_W(`CSA_WORD_W + 1)) out_fifo (
		.clk(axis_s_rclk),
		.rst_n(rst_n),
		.wen(unp_wen),
		.wdata({unp_last, unp_wdata}),
		.full(),
		.free(out_free),
		.rd(out_rd),
		.error_full(out_err_full),
		.error_empty(out_err_empty)
	);

	assign m_tvalid = out_rd.r_ready;
	assign out_rd.ren = m_tvalid && m_tready;
	assign m_tdata = out_rd.rdata[`CSA_WORD_W - 1 : 0];
	assign m_tlast = out_rd.rdata[`CSA_WORD_W];

	assign err_full = in_err_full | out_err_full;
	assign err_empty = in_err_empty | out_err_empty;

endmodule

`default_nettype wire

// File: src/csa_tree.sv
`timescale 1ns/1ps
`default_nettype none

`include "csa_defines.svh"

module csa_tree (
	input logic axis_s_rclk,
	input logic rst_n,
	input logic op_valid,
	input csa_pkg::op_group_u ops,
	output logic sum_valid,
	output csa_pkg::sum_t sum
);

	import csa_pkg::*;

	sum_t op_a;
	sum_t op_b;
	sum_t op_c;
	sum_t op_d;
	sum_t l1_s;
	sum_t l1_c;
	sum_t l2_s;
	sum_t l2_c;
	sum_t s_q;
	sum_t c_q;
	logic v_q;

	assign op_a = sum_t'(ops.ops[0]);
	assign op_b = sum_t'(ops.ops[1]);
	assign op_c = sum_t'(ops.ops[2]);
	assign op_d = sum_t'(ops.ops[3]);

	// First 3:2 layer on a, b, c
	assign l1_s = op_a ^ op_b ^ op_c;
	assign l1_c = ((op_a & op_b) | (op_a & op_c) | (op_b & op_c)) << 1;

	// Second layer folds in d
	assign l2_s = l1_s ^ l1_c ^ op_d;
	assign l2_c = ((l1_s & l1_c) | (l1_s & op_d) | (l1_c & op_d)) << 1;

	always_ff @(posedge axis_s_rclk) begin
		if (!rst_n) begin
			v_q <= 1'b0;
			sum_valid <= 1'b0;
		end else begin
			v_q <= op_valid;
			sum_valid <= v_q;
		end
	end

	// Four 40-bit values stay below 2^42 so the top carry bit is never set
	always_ff @(posedge axis_s_rclk) begin
		if (op_valid) begin
			s_q <= l2_s;
			c_q <= l2_c;
		end
		if (v_q) begin
			sum <= s_q + c_q;
		end
	end

endmodule

`default_nettype wire

// File: src/fifo_rd_if.sv
`timescale 1ns/1ps
`default_nettype none

`include "csa_defines.svh"

interface fifo_rd_if #(
	parameter int DATA_W = `CSA_WORD_W,
	parameter int DEPTH = `CSA_FIFO_DEPTH
);

	logic ren;
	logic [DATA_W - 1 : 0] rdata;
	logic r_ready;
	logic [$clog2(DEPTH + 1) - 1 : 0] count;

	modport fifo (input ren, output rdata, output r_ready, output count);

	// rdata is valid in the same cycle as ren
	modport reader (output ren, input rdata, input r_ready, input count);

endinterface

`default_nettype wire

// File: src/pack_32_to_40.sv
`timescale 1ns/1ps
`default_nettype none

`include "csa_defines.svh"

module pack_32_to_40 (
	input logic axis_s_rclk,
	input logic rst_n,
	fifo_rd_if.reader rd,
	input logic [$clog2(`CSA_FIFO_DEPTH + 1) - 1 : 0] out_free,
	output logic op_valid,
	output csa_pkg::op_group_u ops
);

	// Four operands fill five stream words
	localparam int N_WORDS = 4 * `CSA_OP_W / `CSA_WORD_W;

	logic [2 : 0] word_idx;
	logic start_ok;
	logic take;
	logic last_word;

	// Output room is checked only before the first word of a group
	assign start_ok = (out_free >= `CSA_OUT_HEADROOM);
	assign take = rd.r_ready && ((word_idx != '0) || start_ok);
	assign last_word = (word_idx == 3'(N_WORDS - 1));

	assign rd.ren = take;

	always_ff @(posedge axis_s_rclk) begin
		if (!rst_n) begin
			word_idx <= '0;
			op_valid <= 1'b0;
		end else begin
			op_valid <= take && last_word;
			if (take) begin
				word_idx <= last_word ? '0 : word_idx + 1'b1;
			end
		end
	end

	// Filled as words here, read as operands by the tree
	always_ff @(posedge axis_s_rclk) begin
		if (take) begin
			ops.words[word_idx] <= rd.rdata;
		end
	end

endmodule

`default_nettype wire

// File: src/stream_fifo.sv
`timescale 1ns/1ps
`default_nettype none

`include "csa_defines.svh"

module stream_fifo #(
	parameter int DATA_W = `CSA_WORD_W,
	parameter int DEPTH = `CSA_FIFO_DEPTH,
	localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1,
	localparam int LVL_W = $clog2(DEPTH + 1)
) (
	input logic clk,
	input logic rst_n,
	input logic wen,
	input logic [DATA_W - 1 : 0] wdata,
	output logic full,
	output logic [LVL_W - 1 : 0] free,
	fifo_rd_if.fifo rd,
	output logic error_full,
	output logic error_empty
);

	logic [DATA_W - 1 : 0] mem [DEPTH];
	logic [PTR_W - 1 : 0] wr_ptr;
	logic [PTR_W - 1 : 0] rd_ptr;
	logic [LVL_W - 1 : 0] level;
	logic [LVL_W - 1 : 0] level_next;
	logic at_full;
	logic at_empty;
	logic do_wr;
	logic do_rd;

	assign at_full = (level == LVL_W'(DEPTH));
	assign at_empty = (level == '0);
	assign do_wr = wen && !at_full;
	assign do_rd = rd.ren && !at_empty;

	always_comb begin
		case ({do_wr, do_rd})
			2'b10: level_next = level + 1'b1;
			2'b01: level_next = level - 1'b1;
			default: level_next = level;
		endcase
	end

	always_ff @(posedge clk) begin
		if (do_wr) begin
			mem[wr_ptr] <= wdata;
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			level <= '0;
			// Looks full while in reset, so the writer holds off
			full <= 1'b1;
			error_full <= 1'b0;
			error_empty <= 1'b0;
		end else begin
			if (do_wr) begin
				wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			end
			if (do_rd) begin
				rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			end
			level <= level_next;
			full <= (level_next == LVL_W'(DEPTH));
			error_full <= error_full | (wen && at_full);
			error_empty <= error_empty | (rd.ren && at_empty);
		end
	end

	// Show-ahead read side, zero when nothing is stored
	assign rd.rdata = at_empty ? '0 : mem[rd_ptr];
	assign rd.r_ready = !at_empty;
	assign rd.count = level;
	assign free = LVL_W'(DEPTH) - level;

endmodule

`default_nettype wire

// File: src/unpack_48_to_32.sv
`timescale 1ns/1ps
`default_nettype none

`include "csa_defines.svh"

module unpack_48_to_32 (
	input logic axis_s_rclk,
	input logic rst_n,
	input logic sum_valid,
	input csa_pkg::sum_t sum,
	output logic wen,
	output csa_pkg::word_t wdata,
	output logic last
);

	import csa_pkg::*;

	localparam logic [1 : 0] LAST_BEAT = 2'd2;

	sum_t held;
	sum_pair_u pair;
	logic phase;
	logic draining;
	logic [1 : 0] beat;

	always_ff @(posedge axis_s_rclk) begin
		if (!rst_n) begin
			phase <= 1'b0;
			draining <= 1'b0;
			beat <= '0;
		end else begin
			if (sum_valid) begin
				phase <= ~phase;
			end
			if (sum_valid && phase) begin
				draining <= 1'b1;
				beat <= '0;
			end else if (draining) begin
				if (beat == LAST_BEAT) begin
					draining <= 1'b0;
					beat <= '0;
				end else begin
					beat <= beat + 1'b1;
				end
			end
		end
	end

	// A first sum landing mid-drain only touches held
	always_ff @(posedge axis_s_rclk) begin
		if (sum_valid && !phase) begin
			held <= sum;
		end
		if (sum_valid && phase) begin
			pair.sums[0] <= held;
			pair.sums[1] <= sum;
		end
	end

	assign wen = draining;
	assign wdata = pair.beats[beat];
	assign last = draining && (beat == LAST_BEAT);

endmodule

`default_nettype wire

// File: tb/csa_input.txt
# w0 w1 w2 w3 w4 = five 32-bit input words in stream order, then the expected 48-bit sum
# Lines pair up, each pair gives three output beats
00000000 00000000 00000000 00000000 00000000 000000000000
00000001 00000200 00030000 04000000 00000000 00000000000a
ffffffff ffffffff ffffffff ffffffff ffffffff 03fffffffffc
23456789 00000001 00000000 00000000 00000000 000123456789
00000000 00000000 00000000 01000000 89abcdef 0089abcdef01
00000000 aaaaaa00 5555aaaa 00555555 00000000 00ffffffffff
00000000 00000080 00008000 00800000 80000000 020000000000
00000001 ffffff00 0000ffff 00000000 00000000 010000000000
11111111 22222211 33332222 44333333 44444444 00aaaaaaaaaa
55555555 55555555 55555555 55555555 55555555 015555555554
000000ff 0000ff00 00ff0000 ff000000 00000000 0000000003fc
ffffffff 000001ff 00000000 00000000 00000000 010000000000
34567890 11111112 00001111 00000000 00000000 0023456789a1
00000000 00000000 ffff0000 ffffffff ffffffff 01fffffffffe
00000010 00002000 00300000 40000000 00000000 0000000000a0
0f0f0f0f f0f0f00f 0f0ff0f0 f00f0f0f f0f0f0f0 01fffffffffe
00000003 00000500 00070000 09000000 00000000 000000000018
00000000 00000000 00010000 01800000 80000000 010000000002
adbeef00 000000de 00000000 00000000 00000000 00deadbeef00
00000000 00010000 ff000000 00ffffff 00000000 010000000000

// File: tb/csa_stream_props.sv
`timescale 1ns/1ps
`default_nettype none

`include "csa_defines.svh"

module csa_stream_props (
	input logic axis_s_rclk,
	input logic rst_n,
	input logic m_tvalid,
	input logic m_tready,
	input logic [`CSA_WORD_W - 1 : 0] m_tdata,
	input logic err_full,
	input logic err_empty
);

	// Set once any property below has failed
	logic any_failed = 1'b0;

	// Output FIFO is empty from the first reset edge on
	no_valid_in_reset: assert property (
		@(posedge axis_s_rclk) (!rst_n && $past(!rst_n)) |-> !m_tvalid
	) else begin
		any_failed = 1'b1;
		$error("m_tvalid high while rst_n is low");
	end

	// A stalled beat stays offered and unchanged
	stalled_beat_stable: assert property (
		@(posedge axis_s_rclk) disable iff (!rst_n)
		(m_tvalid && !m_tready) |=> (m_tvalid && $stable(m_tdata))
	) else begin
		any_failed = 1'b1;
		$error("m_tdata changed while m_tready was low");
	end

	no_fifo_errors: assert property (
		@(posedge axis_s_rclk) disable iff (!rst_n)
		!err_full && !err_empty
	) else begin
		any_failed = 1'b1;
		$error("FIFO error flag raised");
	end

endmodule

`default_nettype wire

// File: tb/tb_csa_stream_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "csa_defines.svh"

module tb_csa_stream_top;

	import csa_pkg::*;

	localparam int RESET_CYCLES = 16;
	localparam int LONG_STALL = 150;
	localparam int CYCLES_PER_GROUP = 40;

	logic axis_s_rclk;
	logic rst_n;
	logic s_tvalid;
	logic s_tready;
	word_t s_tdata;
	logic m_tvalid;
	logic m_tready;
	word_t m_tdata;
	logic m_tlast;
	logic err_full;
	logic err_empty;

	word_t in_words[$];
	word_t exp_beats[$];
	int n_groups;
	int total_beats;
	int beats_seen;
	int error_count;
	logic loaded;
	logic saw_backpressure;

	csa_stream_top dut (
		.axis_s_rclk(axis_s_rclk),
		.rst_n(rst_n),
		.s_tvalid(s_tvalid),
		.s_tready(s_tready),
		.s_tdata(s_tdata),
		.m_tvalid(m_tvalid),
		.m_tready(m_tready),
		.m_tdata(m_tdata),
		.m_tlast(m_tlast),
		.err_full(err_full),
		.err_empty(err_empty)
	);

	bind csa_stream_top csa_stream_props props_inst (
		.axis_s_rclk(axis_s_rclk),
		.rst_n(rst_n),
		.m_tvalid(m_tvalid),
		.m_tready(m_tready),
		.m_tdata(m_tdata),
		.err_full(err_full),
		.err_empty(err_empty)
	);

	initial begin
		axis_s_rclk = 1'b0;
		forever #5 axis_s_rclk = ~axis_s_rclk;
	end

	task automatic abort_run();
		error_count++;
		$display("FAIL: see errors above");
		$fatal(1, "stopped at first error");
	endtask

	task automatic report_failure(input string what);
		$display("%s", what);
		abort_run();
	endtask

	task automatic check_word(input word_t got, input word_t exp, input string name);
		if (got !== exp) begin
			$display("error: %s got 0x%h expected 0x%h", name, got, exp);
			abort_run();
		end
	endtask

	task automatic check_flag(input logic got, input logic exp, input string name);
		if (got !== exp) begin
			$display("error: %s got 0x%h expected 0x%h", name, got, exp);
			abort_run();
		end
	endtask

	// Each pair of sums gives three beats of the 96-bit {second, first}
	task automatic read_stimulus();
		int fd;
		int n;
		int i;
		string line;
		word_t w [5];
		sum_t s;
		sum_t first;
		logic [2 * `CSA_SUM_W - 1 : 0] pair;
		fd = $fopen("tb/csa_input.txt", "r");
		if (fd == 0) begin
			report_failure("could not open tb/csa_input.txt");
		end
		n_groups = 0;
		while (!$feof(fd)) begin
			line = "";
			void'($fgets(line, fd));
			// Comment and blank lines do not parse as six fields
			n = $sscanf(line, "%h %h %h %h %h %h", w[0], w[1], w[2], w[3], w[4], s);
			if (n == 6) begin
				for (i = 0; i < 5; i++) begin
					in_words.push_back(w[i]);
				end
				if (n_groups % 2 == 0) begin
					first = s;
				end else begin
					pair = {s, first};
					exp_beats.push_back(pair[31 : 0]);
					exp_beats.push_back(pair[63 : 32]);
					exp_beats.push_back(pair[95 : 64]);
				end
				n_groups++;
			end
		end
		$fclose(fd);
		if (n_groups == 0 || n_groups % 2 != 0) begin
			report_failure("stimulus file must hold an even, nonzero number of groups");
		end
		total_beats = exp_beats.size();
	endtask

	task automatic drive_inputs();
		int idx;
		logic accepted;
		@(posedge axis_s_rclk);
		for (idx = 0; idx < in_words.size(); idx++) begin
			s_tvalid <= 1'b1;
			s_tdata <= in_words[idx];
			accepted = 1'b0;
			while (!accepted) begin
				@(negedge axis_s_rclk);
				accepted = s_tready;
				if (!accepted) begin
					saw_backpressure = 1'b1;
				end
				@(posedge axis_s_rclk);
			end
			if ($urandom_range(3, 0) == 0) begin
				s_tvalid <= 1'b0;
				repeat ($urandom_range(3, 1)) @(posedge axis_s_rclk);
			end
		end
		s_tvalid <= 1'b0;
	endtask

	// Long stall first so both FIFOs fill, then random short and long stalls
	task automatic drive_ready();
		repeat (LONG_STALL) @(posedge axis_s_rclk);
		forever begin
			@(posedge axis_s_rclk);
			if ($urandom_range(31, 0) == 0) begin
				m_tready <= 1'b0;
				repeat ($urandom_range(24, 8)) @(posedge axis_s_rclk);
			end else begin
				m_tready <= ($urandom_range(3, 0) != 0);
			end
		end
	endtask

	initial begin
		rst_n = 1'b0;
		s_tvalid = 1'b0;
		s_tdata = '0;
		m_tready = 1'b0;
		loaded = 1'b0;
		saw_backpressure = 1'b0;
		beats_seen = 0;
		error_count = 0;
		void'($urandom(32'hf8d3_f64c));
		read_stimulus();
		loaded = 1'b1;
		repeat (RESET_CYCLES - 1) @(posedge axis_s_rclk);
		@(negedge axis_s_rclk);
		check_flag(s_tready, 1'b0, "s_tready");
		check_flag(m_tvalid, 1'b0, "m_tvalid");
		check_flag(m_tlast, 1'b0, "m_tlast");
		check_flag(err_full, 1'b0, "err_full");
		check_flag(err_empty, 1'b0, "err_empty");
		@(posedge axis_s_rclk);
		rst_n <= 1'b1;
		@(negedge axis_s_rclk);
		check_flag(s_tready, 1'b0, "s_tready");
		@(negedge axis_s_rclk);
		check_flag(s_tready, 1'b1, "s_tready");
		fork
			drive_inputs();
			drive_ready();
		join_none
		wait (beats_seen == total_beats);
		// Anything still offered now would be a duplicate
		repeat (8) @(negedge axis_s_rclk);
		check_flag(m_tvalid, 1'b0, "m_tvalid");
		if (!saw_backpressure) begin
			report_failure("s_tready never fell during the output stall");
		end
		if (error_count == 0) begin
			$display("PASS: all tests");
		end else begin
			$display("FAIL: see errors above");
		end
		$finish;
	end

	// Output beats and status are sampled away from the clock edge
	initial begin
		wait (loaded);
		forever begin
			@(negedge axis_s_rclk);
			if (dut.props_inst.any_failed) begin
				report_failure("a bound assertion on the output stream failed");
			end
			if (rst_n) begin
				check_flag(err_full, 1'b0, "err_full");
				check_flag(err_empty, 1'b0, "err_empty");
				if (m_tvalid && m_tready) begin
					if (beats_seen >= total_beats) begin
						report_failure("output beat beyond the expected stream");
					end
					check_word(m_tdata, exp_beats[beats_seen], "m_tdata");
					check_flag(m_tlast, (beats_seen % 3 == 2), "m_tlast");
					beats_seen++;
				end
			end
		end
	end

	initial begin
		int limit;
		wait (loaded);
		limit = RESET_CYCLES + LONG_STALL + CYCLES_PER_GROUP * n_groups;
		repeat (limit) @(posedge axis_s_rclk);
		$display("timeout: output stream not complete after %0d cycles", limit);
		$display("FAIL: see errors above");
		$fatal(1, "watchdog expired");
	end

endmodule

`default_nettype wire
